/* lz_pkg.sv */
package lz_pkg;

  // job geometry
  localparam int JOB_LEN = 16;
  localparam int JOB_LEN_LOG2 = 4;
  localparam int HASH_ISSUE_WIDTH = 4;
  localparam int LAZY_MATCH_LEN = 4;

  localparam int ADDR_WIDTH = 16;
  localparam int META_MATCH_LEN_WIDTH = 5;

  // sequence field widths
  localparam int SEQ_LL_BITS = 8;
  localparam int SEQ_ML_BITS = 8;
  localparam int SEQ_OFFSET_BITS = 16;
  localparam int OFFSET_COST_BITS = 4;
  localparam int GAIN_BITS = META_MATCH_LEN_WIDTH + 3;

  // one position of the job table
  typedef struct packed {
    logic                            valid;
    logic [SEQ_OFFSET_BITS-1:0]      offset;
    logic [OFFSET_COST_BITS-1:0]     cost;
    logic [META_MATCH_LEN_WIDTH-1:0] len;
  } job_entry_t;

  typedef struct packed {
    logic [ADDR_WIDTH-1:0]                                head_addr;
    logic [HASH_ISSUE_WIDTH-1:0]                          valid;
    logic [HASH_ISSUE_WIDTH-1:0][ADDR_WIDTH-1:0]           hist_addr;
    logic [HASH_ISSUE_WIDTH-1:0][META_MATCH_LEN_WIDTH-1:0] len;
    logic                                                 delim;
  } hash_batch_t;

  typedef struct packed {
    logic [JOB_LEN_LOG2-1:0]         idx;
    logic [META_MATCH_LEN_WIDTH-1:0] len;
    logic [SEQ_OFFSET_BITS-1:0]      offset;
    logic [OFFSET_COST_BITS-1:0]     cost;
  } pick_t;

  typedef struct packed {
    logic [SEQ_LL_BITS-1:0]     ll;
    logic [SEQ_ML_BITS-1:0]     ml;
    logic [SEQ_OFFSET_BITS-1:0] offset;
    logic                       eoj;
    logic [SEQ_ML_BITS-1:0]     overlap_len;
    logic                       delim;
  } seq_t;

  // index of the highest set bit or zero for a zero offset
  function automatic logic [OFFSET_COST_BITS-1:0] offset_cost(
    input logic [SEQ_OFFSET_BITS-1:0] offset
  );
    logic [OFFSET_COST_BITS-1:0] cost;
    cost = '0;
    for (int i = 0; i < SEQ_OFFSET_BITS; i++) begin
      if (offset[i]) begin
        cost = OFFSET_COST_BITS'(i);
      end
    end
    return cost;
  endfunction

endpackage

/* job_loader.sv */
`timescale 1ns/1ps

module job_loader #(
  parameter int JOB_LEN = lz_pkg::JOB_LEN
) (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                hash_batch_valid_i,
  input  lz_pkg::hash_batch_t                 hash_batch_i,
  output logic                                hash_batch_ready_o,
  input  logic                                job_release_i,
  output logic                                job_full_o,
  output lz_pkg::job_entry_t [JOB_LEN-1:0]    job_table_o,
  output logic                                job_delim_o
);
  import lz_pkg::*;

  localparam int BATCHES = JOB_LEN / HASH_ISSUE_WIDTH;
  localparam int CNT_W = (BATCHES > 1) ? $clog2(BATCHES) : 1;

  logic [CNT_W-1:0] batch_cnt_q;
  logic job_full_q;
  logic take;
  logic last_batch;
  logic [HASH_ISSUE_WIDTH-1:0][ADDR_WIDTH-1:0] lane_dist;
  job_entry_t [HASH_ISSUE_WIDTH-1:0] lane_entry;

  assign hash_batch_ready_o = !job_full_q;
  assign job_full_o = job_full_q;
  assign take = hash_batch_valid_i && hash_batch_ready_o;
  assign last_batch = (batch_cnt_q == CNT_W'(BATCHES - 1));

  // lane offset uses this batch's own head address
  always_comb begin
    for (int l = 0; l < HASH_ISSUE_WIDTH; l++) begin
      lane_dist[l] = hash_batch_i.head_addr + ADDR_WIDTH'(l) - hash_batch_i.hist_addr[l];
      lane_entry[l].valid = hash_batch_i.valid[l];
      lane_entry[l].offset = lane_dist[l][SEQ_OFFSET_BITS-1:0];
      lane_entry[l].cost = offset_cost(lane_dist[l][SEQ_OFFSET_BITS-1:0]);
      lane_entry[l].len = hash_batch_i.len[l];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      batch_cnt_q <= '0;
      job_full_q <= 1'b0;
    end else begin
      if (take) begin
        if (last_batch) begin
          batch_cnt_q <= '0;
          job_full_q <= 1'b1;
        end else begin
          batch_cnt_q <= batch_cnt_q + CNT_W'(1);
        end
      end
      if (job_release_i) begin
        job_full_q <= 1'b0;
      end
    end
  end

  // table slice for the current batch
  always_ff @(posedge clk) begin
    if (take) begin
      for (int l = 0; l < HASH_ISSUE_WIDTH; l++) begin
        job_table_o[int'(batch_cnt_q) * HASH_ISSUE_WIDTH + l] <= lane_entry[l];
      end
      if (last_batch) begin
        job_delim_o <= hash_batch_i.delim;
      end
    end
  end

endmodule

/* head_seeker.sv */
`timescale 1ns/1ps

module head_seeker #(
  parameter int JOB_LEN = lz_pkg::JOB_LEN
) (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            job_full_i,
  input  logic [JOB_LEN-1:0]              job_valid_bits_i,
  input  logic                            resume_pulse_i,
  input  logic [lz_pkg::JOB_LEN_LOG2-1:0] resume_idx_i,
  output logic                            head_pulse_o,
  output logic [lz_pkg::JOB_LEN_LOG2-1:0] head_idx_o,
  output logic                            tail_pulse_o
);
  import lz_pkg::*;

  logic job_full_q;
  logic scanning_q;
  logic [JOB_LEN_LOG2-1:0] scan_ptr_q;
  logic [JOB_LEN-1:0] ahead;

  // valid bits from the pointer onwards
  assign ahead = job_valid_bits_i >> scan_ptr_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      job_full_q <= 1'b0;
      scanning_q <= 1'b0;
      scan_ptr_q <= '0;
      head_pulse_o <= 1'b0;
      head_idx_o <= '0;
      tail_pulse_o <= 1'b0;
    end else begin
      job_full_q <= job_full_i;
      head_pulse_o <= 1'b0;
      tail_pulse_o <= 1'b0;
      if (job_full_i && !job_full_q) begin
        scanning_q <= 1'b1;
        scan_ptr_q <= '0;
      end else if (resume_pulse_i) begin
        scanning_q <= 1'b1;
        scan_ptr_q <= resume_idx_i;
      end else if (scanning_q) begin
        if (ahead[0]) begin
          head_pulse_o <= 1'b1;
          head_idx_o <= scan_ptr_q;
          scanning_q <= 1'b0;
        end else if (int'(scan_ptr_q) == JOB_LEN - 1) begin
          // nothing left before the job end
          tail_pulse_o <= 1'b1;
          scanning_q <= 1'b0;
        end else if (int'(scan_ptr_q) < JOB_LEN - 8 && ahead[7:0] == 8'h00) begin
          scan_ptr_q <= scan_ptr_q + JOB_LEN_LOG2'(4);
        end else if (int'(scan_ptr_q) < JOB_LEN - 4 && ahead[3:0] == 4'h0) begin
          scan_ptr_q <= scan_ptr_q + JOB_LEN_LOG2'(2);
        end else begin
          scan_ptr_q <= scan_ptr_q + JOB_LEN_LOG2'(1);
        end
      end
    end
  end

endmodule

/* lazy_picker.sv */
`timescale 1ns/1ps

module lazy_picker #(
  parameter int JOB_LEN = lz_pkg::JOB_LEN,
  parameter int LAZY_MATCH_LEN = lz_pkg::LAZY_MATCH_LEN
) (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             head_pulse_i,
  input  logic [lz_pkg::JOB_LEN_LOG2-1:0]  head_idx_i,
  input  lz_pkg::job_entry_t [JOB_LEN-1:0] job_table_i,
  input  logic                             pick_taken_i,
  output logic                             pick_valid_o,
  output lz_pkg::pick_t                    pick_o
);
  import lz_pkg::*;

  localparam int SLOT_W = (LAZY_MATCH_LEN > 1) ? $clog2(LAZY_MATCH_LEN) : 1;

  logic win_live_q;
  logic [LAZY_MATCH_LEN-1:0] win_valid_q;
  job_entry_t [LAZY_MATCH_LEN-1:0] win_q;
  logic [LAZY_MATCH_LEN-1:0][JOB_LEN_LOG2-1:0] win_idx_q;
  logic [LAZY_MATCH_LEN-1:0][JOB_LEN_LOG2:0] win_pos;
  logic [LAZY_MATCH_LEN-1:0][GAIN_BITS-1:0] gain;
  logic [SLOT_W-1:0] best_w;
  logic [GAIN_BITS-1:0] best_gain;

  // one extra bit so positions past the job end are visible
  always_comb begin
    for (int w = 0; w < LAZY_MATCH_LEN; w++) begin
      win_pos[w] = {1'b0, head_idx_i} + (JOB_LEN_LOG2 + 1)'(w);
    end
  end

  // copy the window in the first cycle
  always_ff @(posedge clk) begin
    if (head_pulse_i) begin
      for (int w = 0; w < LAZY_MATCH_LEN; w++) begin
        win_idx_q[w] <= win_pos[w][JOB_LEN_LOG2-1:0];
        if (int'(win_pos[w]) < JOB_LEN) begin
          win_valid_q[w] <= job_table_i[win_pos[w][JOB_LEN_LOG2-1:0]].valid;
          win_q[w] <= job_table_i[win_pos[w][JOB_LEN_LOG2-1:0]];
        end else begin
          win_valid_q[w] <= 1'b0;
          win_q[w] <= '0;
        end
      end
    end
  end

  // gain = 4*len + 4*(window - slot) - offset cost
  always_comb begin
    for (int w = 0; w < LAZY_MATCH_LEN; w++) begin
      gain[w] = (GAIN_BITS'(win_q[w].len) << 2)
              + GAIN_BITS'(4 * (LAZY_MATCH_LEN - w))
              - GAIN_BITS'(win_q[w].cost);
    end
    best_w = '0;
    best_gain = gain[0];
    // strict compare keeps the lower slot on a tie
    for (int w = 1; w < LAZY_MATCH_LEN; w++) begin
      if (win_valid_q[w] && gain[w] > best_gain) begin
        best_w = SLOT_W'(w);
        best_gain = gain[w];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      win_live_q <= 1'b0;
      pick_valid_o <= 1'b0;
    end else begin
      win_live_q <= head_pulse_i;
      if (win_live_q) begin
        pick_valid_o <= 1'b1;
      end else if (pick_taken_i) begin
        pick_valid_o <= 1'b0;
      end
    end
  end

  // register the winner in the second cycle
  always_ff @(posedge clk) begin
    if (win_live_q) begin
      pick_o.idx <= win_idx_q[best_w];
      pick_o.len <= win_q[best_w].len;
      pick_o.offset <= win_q[best_w].offset;
      pick_o.cost <= win_q[best_w].cost;
    end
  end

endmodule

/* seq_emitter.sv */
`timescale 1ns/1ps

module seq_emitter #(
  parameter int JOB_LEN = lz_pkg::JOB_LEN
) (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            job_full_i,
  input  logic                            job_delim_i,
  input  logic                            pick_valid_i,
  input  lz_pkg::pick_t                   pick_i,
  input  logic                            tail_pulse_i,
  input  logic                            seq_ready_i,
  output logic                            seq_valid_o,
  output lz_pkg::seq_t                    seq_o,
  output logic                            pick_taken_o,
  output logic                            resume_pulse_o,
  output logic [lz_pkg::JOB_LEN_LOG2-1:0] resume_idx_o,
  output logic                            job_release_o
);
  import lz_pkg::*;

  logic tail_q;
  logic [JOB_LEN_LOG2-1:0] seq_head_q;
  logic [SEQ_ML_BITS-1:0] next_pos;
  logic [SEQ_LL_BITS-1:0] pick_ll;
  logic ends_job;
  logic fire;

  assign seq_valid_o = pick_valid_i || tail_q;
  assign fire = seq_valid_o && seq_ready_i;
  assign pick_taken_o = fire && pick_valid_i;

  always_comb begin
    next_pos = SEQ_ML_BITS'(pick_i.idx) + SEQ_ML_BITS'(pick_i.len);
    pick_ll = SEQ_LL_BITS'(pick_i.idx) - SEQ_LL_BITS'(seq_head_q);
    ends_job = tail_q || (next_pos >= SEQ_ML_BITS'(JOB_LEN));
    seq_o = '0;
    seq_o.delim = job_delim_i;
    seq_o.eoj = ends_job;
    if (tail_q) begin
      // literal-only tail up to the job end
      seq_o.ll = SEQ_LL_BITS'(JOB_LEN) - SEQ_LL_BITS'(seq_head_q);
    end else if (ends_job && job_delim_i) begin
      // match of a delimited job turns into literals
      seq_o.ll = pick_ll + SEQ_LL_BITS'(JOB_LEN) - SEQ_LL_BITS'(pick_i.idx);
    end else begin
      seq_o.ll = pick_ll;
      seq_o.ml = SEQ_ML_BITS'(pick_i.len);
      seq_o.offset = pick_i.offset;
      if (ends_job) begin
        seq_o.overlap_len = next_pos - SEQ_ML_BITS'(JOB_LEN);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tail_q <= 1'b0;
      seq_head_q <= '0;
      resume_pulse_o <= 1'b0;
      resume_idx_o <= '0;
      job_release_o <= 1'b0;
    end else begin
      resume_pulse_o <= 1'b0;
      job_release_o <= 1'b0;
      if (tail_pulse_i) begin
        tail_q <= 1'b1;
      end
      if (fire) begin
        tail_q <= 1'b0;
        if (ends_job) begin
          job_release_o <= 1'b1;
        end else begin
          resume_pulse_o <= 1'b1;
          resume_idx_o <= next_pos[JOB_LEN_LOG2-1:0];
          seq_head_q <= next_pos[JOB_LEN_LOG2-1:0];
        end
      end
      // head restarts with every new job
      if (!job_full_i) begin
        seq_head_q <= '0;
      end
    end
  end

endmodule

/* lz_job_pe.sv */
`timescale 1ns/1ps

module lz_job_pe #(
  parameter int JOB_LEN = lz_pkg::JOB_LEN,
  parameter int LAZY_MATCH_LEN = lz_pkg::LAZY_MATCH_LEN
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                hash_batch_valid_i,
  input  lz_pkg::hash_batch_t hash_batch_i,
  output logic                hash_batch_ready_o,
  output logic                seq_valid_o,
  output lz_pkg::seq_t        seq_o,
  input  logic                seq_ready_i
);
  import lz_pkg::*;

  job_entry_t [JOB_LEN-1:0] job_table;
  logic [JOB_LEN-1:0] job_valid_bits;
  logic job_full;
  logic job_delim;
  logic job_release;
  logic head_pulse;
  logic tail_pulse;
  logic resume_pulse;
  logic pick_valid;
  logic pick_taken;
  logic [JOB_LEN_LOG2-1:0] head_idx;
  logic [JOB_LEN_LOG2-1:0] resume_idx;
  pick_t pick;

  always_comb begin
    for (int p = 0; p < JOB_LEN; p++) begin
      job_valid_bits[p] = job_table[p].valid;
    end
  end

  job_loader #(.JOB_LEN(JOB_LEN)) u_loader (
    .clk(clk), .rst_n(rst_n),
    .hash_batch_valid_i(hash_batch_valid_i), .hash_batch_i(hash_batch_i),
    .hash_batch_ready_o(hash_batch_ready_o), .job_release_i(job_release),
    .job_full_o(job_full), .job_table_o(job_table), .job_delim_o(job_delim)
  );

  head_seeker #(.JOB_LEN(JOB_LEN)) u_seeker (
    .clk(clk), .rst_n(rst_n), .job_full_i(job_full), .job_valid_bits_i(job_valid_bits),
    .resume_pulse_i(resume_pulse), .resume_idx_i(resume_idx),
    .head_pulse_o(head_pulse), .head_idx_o(head_idx), .tail_pulse_o(tail_pulse)
  );

  lazy_picker #(.JOB_LEN(JOB_LEN), .LAZY_MATCH_LEN(LAZY_MATCH_LEN)) u_picker (
    .clk(clk), .rst_n(rst_n), .head_pulse_i(head_pulse), .head_idx_i(head_idx),
    .job_table_i(job_table), .pick_taken_i(pick_taken),
    .pick_valid_o(pick_valid), .pick_o(pick)
  );

  seq_emitter #(.JOB_LEN(JOB_LEN)) u_emitter (
    .clk(clk), .rst_n(rst_n), .job_full_i(job_full), .job_delim_i(job_delim),
    .pick_valid_i(pick_valid), .pick_i(pick), .tail_pulse_i(tail_pulse),
    .seq_ready_i(seq_ready_i), .seq_valid_o(seq_valid_o), .seq_o(seq_o),
    .pick_taken_o(pick_taken), .resume_pulse_o(resume_pulse),
    .resume_idx_o(resume_idx), .job_release_o(job_release)
  );

endmodule

/* lz_job_pe_properties.sv */
`timescale 1ns/1ps

module lz_job_pe_properties (
  input logic         clk,
  input logic         rst_n,
  input logic         batch_ready_i,
  input logic         seq_valid_i,
  input lz_pkg::seq_t seq_i,
  input logic         seq_ready_i
);
  import lz_pkg::*;

  int unsigned fail_cnt = 0;

  // a stalled sequence stays put
  stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
    seq_valid_i && !seq_ready_i |=> seq_valid_i && $stable(seq_i))
  else begin
    fail_cnt++;
    $error("seq_o changed or dropped while stalled");
  end

  // loading and emitting never overlap
  no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
    !(batch_ready_i && seq_valid_i))
  else begin
    fail_cnt++;
    $error("hash_batch_ready_o and seq_valid_o high together");
  end

  reset_levels: assert property (@(posedge clk) !rst_n |=> !seq_valid_i && batch_ready_i)
  else begin
    fail_cnt++;
    $error("wrong handshake levels after reset");
  end

endmodule

bind lz_job_pe lz_job_pe_properties u_props (
  .clk(clk), .rst_n(rst_n), .batch_ready_i(hash_batch_ready_o),
  .seq_valid_i(seq_valid_o), .seq_i(seq_o), .seq_ready_i(seq_ready_i)
);

/* lz_job_pe_tb.sv */
`timescale 1ns/1ps

module lz_job_pe_tb;
  import lz_pkg::*;

  localparam int CLK_PERIOD = 4;
  localparam int N_JOBS = 40;
  localparam int BATCHES = JOB_LEN / HASH_ISSUE_WIDTH;

  logic clk;
  logic rst_n;
  logic hash_batch_valid_i;
  hash_batch_t hash_batch_i;
  logic hash_batch_ready_o;
  logic seq_valid_o;
  seq_t seq_o;
  logic seq_ready_i;

  integer seed = 91658;
  hash_batch_t batch_mem [N_JOBS*BATCHES];
  int gap_mem [N_JOBS*BATCHES];
  seq_t exp_q [$];
  seq_t exp_seq;
  int jobs_done = 0;
  bit loaded = 1'b0;

  lz_job_pe #(.JOB_LEN(JOB_LEN), .LAZY_MATCH_LEN(LAZY_MATCH_LEN)) uut (
    .clk(clk), .rst_n(rst_n),
    .hash_batch_valid_i(hash_batch_valid_i), .hash_batch_i(hash_batch_i),
    .hash_batch_ready_o(hash_batch_ready_o),
    .seq_valid_o(seq_valid_o), .seq_o(seq_o), .seq_ready_i(seq_ready_i)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic halt_run();
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped after a failure");
  endtask

  task automatic report_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    $display("FAIL time=%0t %s got=%0d expected=%0d", $time, name, got, exp);
    halt_run();
  endtask

  task automatic check_seq(input seq_t got, input seq_t exp);
    if (got.ll !== exp.ll) report_value("seq_o.ll", got.ll, exp.ll);
    if (got.ml !== exp.ml) report_value("seq_o.ml", got.ml, exp.ml);
    if (got.offset !== exp.offset) report_value("seq_o.offset", got.offset, exp.offset);
    if (got.eoj !== exp.eoj) report_value("seq_o.eoj", got.eoj, exp.eoj);
    if (got.overlap_len !== exp.overlap_len) begin
      report_value("seq_o.overlap_len", got.overlap_len, exp.overlap_len);
    end
    if (got.delim !== exp.delim) report_value("seq_o.delim", got.delim, exp.delim);
  endtask

  task automatic check_ready(input bit got, input bit exp);
    if (got !== exp) report_value("hash_batch_ready_o", got, exp);
  endtask

  function automatic int msb_index(input logic [SEQ_OFFSET_BITS-1:0] v);
    for (int i = SEQ_OFFSET_BITS - 1; i > 0; i--) begin
      if (v[i]) return i;
    end
    return 0;
  endfunction

  // append the expected sequences of one job to exp_q
  function automatic void expand_job(input hash_batch_t [BATCHES-1:0] jb);
    logic [JOB_LEN-1:0] vld;
    int len_a [JOB_LEN];
    int cost_a [JOB_LEN];
    logic [SEQ_OFFSET_BITS-1:0] off_a [JOB_LEN];
    int bt, l, ptr, head, p, b, q, best, g, nxt;
    bit delim, done;
    seq_t s;
    delim = jb[BATCHES-1].delim;
    for (int k = 0; k < JOB_LEN; k++) begin
      bt = k / HASH_ISSUE_WIDTH;
      l = k % HASH_ISSUE_WIDTH;
      vld[k] = jb[bt].valid[l];
      len_a[k] = jb[bt].len[l];
      off_a[k] = jb[bt].head_addr + SEQ_OFFSET_BITS'(l) - jb[bt].hist_addr[l];
      cost_a[k] = msb_index(off_a[k]);
    end
    ptr = 0;
    head = 0;
    done = 1'b0;
    while (!done) begin
      p = ptr;
      while (p < JOB_LEN && !vld[p]) p++;
      s = '0;
      s.delim = delim;
      if (p >= JOB_LEN) begin
        // literal tail
        s.ll = SEQ_LL_BITS'(JOB_LEN - head);
        s.eoj = 1'b1;
        done = 1'b1;
      end else begin
        b = p;
        best = 4 * len_a[p] + 4 * LAZY_MATCH_LEN - cost_a[p];
        for (int w = 1; w < LAZY_MATCH_LEN; w++) begin
          q = p + w;
          if (q < JOB_LEN && vld[q]) begin
            g = 4 * len_a[q] + 4 * (LAZY_MATCH_LEN - w) - cost_a[q];
            if (g > best) begin
              best = g;
              b = q;
            end
          end
        end
        nxt = b + len_a[b];
        s.ll = SEQ_LL_BITS'(b - head);
        s.ml = SEQ_ML_BITS'(len_a[b]);
        s.offset = off_a[b];
        if (nxt >= JOB_LEN) begin
          s.eoj = 1'b1;
          s.overlap_len = SEQ_ML_BITS'(nxt - JOB_LEN);
          done = 1'b1;
          if (delim) begin
            s.ll = SEQ_LL_BITS'(JOB_LEN - head);
            s.ml = '0;
            s.offset = '0;
            s.overlap_len = '0;
          end
        end else begin
          ptr = nxt;
          head = nxt;
        end
      end
      exp_q.push_back(s);
    end
  endfunction

  task automatic make_jobs();
    hash_batch_t b;
    hash_batch_t [BATCHES-1:0] jb;
    logic [SEQ_OFFSET_BITS-1:0] want;
    for (int j = 0; j < N_JOBS; j++) begin
      for (int bt = 0; bt < BATCHES; bt++) begin
        b = '0;
        b.head_addr = ADDR_WIDTH'($random(seed));
        b.delim = (j % 5 == 4);
        for (int l = 0; l < HASH_ISSUE_WIDTH; l++) begin
          b.valid[l] = $random(seed) & 1;
          b.len[l] = META_MATCH_LEN_WIDTH'(3 + $unsigned($random(seed)) % 10);
          // history may wrap below zero for large offsets
          want = SEQ_OFFSET_BITS'($random(seed)) >> ($unsigned($random(seed)) % 16);
          b.hist_addr[l] = b.head_addr + ADDR_WIDTH'(l) - want;
        end
        if (j % 7 == 3) b.valid = '0;
        jb[bt] = b;
        batch_mem[j*BATCHES+bt] = b;
        gap_mem[j*BATCHES+bt] = $unsigned($random(seed)) % 3;
      end
      expand_job(jb);
    end
  endtask

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    hash_batch_valid_i = 1'b0;
    hash_batch_i = '0;
    seq_ready_i = 1'b0;
    make_jobs();
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    for (int i = 0; i < N_JOBS * BATCHES; i++) begin
      repeat (gap_mem[i]) @(negedge clk);
      hash_batch_valid_i = 1'b1;
      hash_batch_i = batch_mem[i];
      @(posedge clk);
      while (!hash_batch_ready_o) @(posedge clk);
      @(negedge clk);
      hash_batch_valid_i = 1'b0;
    end
    wait (jobs_done == N_JOBS);
    repeat (20) @(posedge clk);
    if (uut.u_props.fail_cnt == 0) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      $display("run ended with %0d assertion failures", uut.u_props.fail_cnt);
      halt_run();
    end
  end

  // random back-pressure
  initial begin
    wait (rst_n === 1'b1);
    forever begin
      @(negedge clk);
      seq_ready_i = ($random(seed) & 3) != 0;
    end
  end

  always @(posedge clk) begin
    if (rst_n) begin
      if (loaded) check_ready(hash_batch_ready_o, 1'b0);
      if (hash_batch_valid_i && hash_batch_ready_o) begin
        if (hash_batch_i == batch_mem[(jobs_done + 1) * BATCHES - 1]) loaded = 1'b1;
      end
      if (seq_valid_o && seq_ready_i) begin
        if (exp_q.size() == 0) begin
          $display("a sequence came out after all expected sequences were seen");
          halt_run();
        end else begin
          exp_seq = exp_q.pop_front();
          check_seq(seq_o, exp_seq);
          if (exp_seq.eoj) begin
            loaded = 1'b0;
            jobs_done++;
          end
        end
      end
    end
  end

  initial begin
    #((N_JOBS * 200 + 8) * CLK_PERIOD);
    $display("timeout: sequences missing");
    halt_run();
  end

endmodule

/* sim.f */
lz_pkg.sv
job_loader.sv
head_seeker.sv
lazy_picker.sv
seq_emitter.sv
lz_job_pe.sv
lz_job_pe_properties.sv
lz_job_pe_tb.sv

/* Bender.yml */
package:
  name: lz_job_pe

sources:
  - lz_pkg.sv
  - job_loader.sv
  - head_seeker.sv
  - lazy_picker.sv
  - seq_emitter.sv
  - lz_job_pe.sv
  - target: test
    files:
      - lz_job_pe_properties.sv
      - lz_job_pe_tb.sv
